/* hw/MemorySystemTypes.sv */
/*
 * Memory system definitions
 * Memory geometry, serial id types, request and response structs
 * and the memory state encoding
 */
package MemorySystemTypes;

    // Memory geometry
    localparam int MEM_WORDS = 64;
    localparam int MEM_ADDR_WIDTH = 6;
    localparam int MEM_DATA_WIDTH = 32;
    localparam int MEM_SERIAL_WIDTH = 4; // Serials wrap at 16

    typedef logic [MEM_ADDR_WIDTH-1:0] MemAddrPath;   // Word address
    typedef logic [MEM_DATA_WIDTH-1:0] MemDataPath;
    typedef logic [MEM_SERIAL_WIDTH-1:0] MemReadSerial;
    typedef logic [MEM_SERIAL_WIDTH-1:0] MemWriteSerial;

    // Request toward the memory port
    typedef struct packed {
        MemAddrPath addr;
        MemDataPath writeData;
        logic re;
        logic we;
    } MemAccessReq;

    // Read data returned with the serial of its request
    typedef struct packed {
        logic valid;
        MemReadSerial serial;
        MemDataPath data;
    } MemReadResp;

    // Write completion notice
    typedef struct packed {
        logic valid;
        MemWriteSerial serial;
    } MemWriteResp;

    typedef enum logic {
        MEM_CLEARING,
        MEM_READY
    } MemState;

endpackage : MemorySystemTypes

/* hw/BoardTypes.sv */
/*
 * Board level definitions
 * Reset timing, loader address map, Wishbone structs and FSM encodings
 */
package BoardTypes;

    localparam int RESET_HOLD_CYCLES = 8;   // rst cycles after the trigger ends
    localparam int RESET_COUNT_WIDTH = $clog2(RESET_HOLD_CYCLES + 1);
    localparam logic [31:0] LOADER_DONE_ADDR = 32'h100;
    localparam int WB_WIDTH = 32;

    typedef logic [RESET_COUNT_WIDTH-1:0] ResetCount;
    typedef logic [WB_WIDTH-1:0] WbWord;

    // Host to loader
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        WbWord adr; // Word address
        WbWord dat;
    } WbReq;

    // Loader to host
    typedef struct packed {
        logic ack;
        WbWord dat;
    } WbResp;

    typedef enum logic { RST_HOLD, RST_RUN } ResetState;
    typedef enum logic [1:0] { LD_IDLE, LD_WRITE, LD_ACK } LoaderState;

endpackage : BoardTypes

/* hw/ResetController.sv */
/*
 * Reset controller
 * Synchronizes the active-low board reset and stretches it into rst
 */
`timescale 1ns/1ps

module ResetController (
    input  logic clk,
    input  logic negResetIn,
    output logic rst
);
    import BoardTypes::*;

    logic syncFirst;
    logic rstTrigger; // Synchronized, active high
    ResetState state;
    ResetCount holdCount;

    // Two-stage synchronizer on the inverted input
    always_ff @(posedge clk) begin
        syncFirst <= ~negResetIn;
        rstTrigger <= syncFirst;
    end

    always_ff @(posedge clk) begin
        if (rstTrigger) begin
            state <= RST_HOLD;
            holdCount <= ResetCount'(RESET_HOLD_CYCLES);
        end else if (state == RST_HOLD) begin
            // Leave on the last hold cycle
            if (holdCount == ResetCount'(1)) begin
                state <= RST_RUN;
            end
            holdCount <= holdCount - 1'b1;
        end
    end

    assign rst = (state == RST_HOLD);

endmodule : ResetController

/* hw/ProgramLoader.sv */
/*
 * Program loader
 * Wishbone classic slave that writes the memory image and raises
 * programLoaded once the host writes the done address
 */
`timescale 1ns/1ps

module ProgramLoader (
    input  logic clk,
    input  logic rst,
    input  BoardTypes::WbReq wbReq,
    output BoardTypes::WbResp wbResp,
    output MemorySystemTypes::MemAccessReq loadReq,
    input  logic memBusy,
    output logic programLoaded
);
    import BoardTypes::*;
    import MemorySystemTypes::*;

    LoaderState state;
    logic cycleStart;
    logic memWriteHit;  // Address falls inside the memory
    logic doneHit;

    assign cycleStart = wbReq.cyc & wbReq.stb;
    assign memWriteHit = wbReq.we && (wbReq.adr < WbWord'(MEM_WORDS));
    assign doneHit = wbReq.we && (wbReq.adr == LOADER_DONE_ADDR);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LD_IDLE;
            programLoaded <= 1'b0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (cycleStart) begin
                        state <= memWriteHit ? LD_WRITE : LD_ACK;
                        if (doneHit) begin
                            programLoaded <= 1'b1; // Sticky until reset
                        end
                    end
                end
                LD_WRITE: begin
                    if (!memBusy) state <= LD_ACK; // Write accepted this cycle
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    // Host holds adr and dat until ack
    always_comb begin
        loadReq.addr = wbReq.adr[MEM_ADDR_WIDTH-1:0];
        loadReq.writeData = wbReq.dat;
        loadReq.re = 1'b0;
        loadReq.we = (state == LD_WRITE);
    end

    assign wbResp.ack = (state == LD_ACK);
    assign wbResp.dat = {{(WB_WIDTH-1){1'b0}}, programLoaded}; // Status word

endmodule : ProgramLoader

/* hw/MemoryAccessArbiter.sv */
/*
 * Memory access arbiter
 * Gives the memory port to the loader until loading ends, then to
 * the core, and derives the core reset
 */
`timescale 1ns/1ps

module MemoryAccessArbiter (
    input  logic rst,
    input  logic programLoaded,
    input  MemorySystemTypes::MemAccessReq loadReq,
    input  MemorySystemTypes::MemAccessReq coreReq,
    output MemorySystemTypes::MemAccessReq memReq,
    output logic coreRst
);

    // Core stays in reset until the image is complete
    assign coreRst = rst | ~programLoaded;

    always_comb begin
        if (!programLoaded) begin
            memReq = loadReq;
        end else begin
            memReq = coreReq;
            // Requests from a core in reset are masked
            if (coreRst) begin
                memReq.re = 1'b0;
                memReq.we = 1'b0;
            end
        end
    end

endmodule : MemoryAccessArbiter

/* hw/PipelinedMemory.sv */
/*
 * Pipelined internal memory
 * Request, array and response stages with read and write serials,
 * cleared word by word after reset
 */
`timescale 1ns/1ps

module PipelinedMemory (
    input  logic clk,
    input  logic rst,
    input  MemorySystemTypes::MemAccessReq memReq,
    output logic memBusy,
    output MemorySystemTypes::MemReadSerial nextReadSerial,
    output MemorySystemTypes::MemWriteSerial nextWriteSerial,
    output MemorySystemTypes::MemReadResp readResp,
    output MemorySystemTypes::MemWriteResp writeResp
);
    import MemorySystemTypes::*;

    MemDataPath memArray [MEM_WORDS];
    MemState state;
    MemAddrPath clearAddr;
    logic readAccept, writeAccept;

    logic s1Read, s1Write;      // Request stage
    MemAddrPath s1Addr;
    MemDataPath s1Data;
    MemReadSerial s1ReadSerial;
    MemWriteSerial s1WriteSerial;

    logic s2Read, s2Write;      // Array stage
    MemDataPath s2Data;
    MemReadSerial s2ReadSerial;
    MemWriteSerial s2WriteSerial;

    assign memBusy = (state == MEM_CLEARING);
    assign writeAccept = memReq.we & ~memBusy;
    assign readAccept = memReq.re & ~memReq.we & ~memBusy; // Write wins

    // Clear FSM, serial counters and stage valids
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MEM_CLEARING;
            clearAddr <= '0;
            nextReadSerial <= '0;
            nextWriteSerial <= '0;
            {s1Read, s1Write, s2Read, s2Write} <= '0;
        end else begin
            if (state == MEM_CLEARING) begin
                clearAddr <= clearAddr + 1'b1;
                if (clearAddr == MemAddrPath'(MEM_WORDS - 1)) state <= MEM_READY;
            end
            if (readAccept) nextReadSerial <= nextReadSerial + 1'b1;
            if (writeAccept) nextWriteSerial <= nextWriteSerial + 1'b1;
            s1Read <= readAccept;
            s1Write <= writeAccept;
            s2Read <= s1Read;
            s2Write <= s1Write;
        end
    end

    // Request stage payload
    always_ff @(posedge clk) begin
        s1Addr <= memReq.addr;
        s1Data <= memReq.writeData;
        s1ReadSerial <= nextReadSerial;
        s1WriteSerial <= nextWriteSerial;
    end

    // Array stage
    always_ff @(posedge clk) begin
        if (state == MEM_CLEARING) begin
            memArray[clearAddr] <= '0;
        end else if (s1Write) begin
            memArray[s1Addr] <= s1Data;
        end
        s2Data <= memArray[s1Addr]; // Old value on a write
        s2ReadSerial <= s1ReadSerial;
        s2WriteSerial <= s1WriteSerial;
    end

    // Response stage
    always_ff @(posedge clk) begin
        if (rst) begin
            readResp <= '0;
            writeResp <= '0;
        end else begin
            readResp <= '{valid: s2Read, serial: s2ReadSerial, data: s2Data};
            writeResp <= '{valid: s2Write, serial: s2WriteSerial};
        end
    end

endmodule : PipelinedMemory

/* hw/MemorySubsystem.sv */
/*
 * Memory subsystem top level
 * Reset controller, program loader, access arbiter and internal memory
 */
`timescale 1ns/1ps

module MemorySubsystem (
    input  logic clk,
    input  logic negResetIn,
    input  BoardTypes::WbReq wbReq,
    output BoardTypes::WbResp wbResp,
    input  MemorySystemTypes::MemAccessReq coreReq,
    output logic coreRst,
    output logic memBusy,
    output MemorySystemTypes::MemReadSerial nextReadSerial,
    output MemorySystemTypes::MemWriteSerial nextWriteSerial,
    output MemorySystemTypes::MemReadResp readResp,
    output MemorySystemTypes::MemWriteResp writeResp
);
    import MemorySystemTypes::*;

    logic rst;
    logic programLoaded;
    MemAccessReq loadReq;   // Loader side of the arbiter
    MemAccessReq memReq;    // Arbiter to memory

    ResetController resetController_i (
        .clk        (clk),
        .negResetIn (negResetIn),
        .rst        (rst)
    );

    ProgramLoader programLoader_i (
        .clk           (clk),
        .rst           (rst),
        .wbReq         (wbReq),
        .wbResp        (wbResp),
        .loadReq       (loadReq),
        .memBusy       (memBusy),
        .programLoaded (programLoaded)
    );

    MemoryAccessArbiter memoryAccessArbiter_i (
        .rst           (rst),
        .programLoaded (programLoaded),
        .loadReq       (loadReq),
        .coreReq       (coreReq),
        .memReq        (memReq),
        .coreRst       (coreRst)
    );

    PipelinedMemory pipelinedMemory_i (
        .clk             (clk),
        .rst             (rst),
        .memReq          (memReq),
        .memBusy         (memBusy),
        .nextReadSerial  (nextReadSerial),
        .nextWriteSerial (nextWriteSerial),
        .readResp        (readResp),
        .writeResp       (writeResp)
    );

endmodule : MemorySubsystem

/* verif/MemorySubsystemTb.sv */
/*
 * Testbench for the memory subsystem
 * Clock and reset, LFSR stimulus, memory model, response scoreboard
 * and assertion checks
 */
`timescale 1ns/1ps

module MemorySubsystemTb;
    import MemorySystemTypes::*;
    import BoardTypes::*;

    localparam logic [31:0] LFSR_SEED = 32'h1b0cc226;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;
    localparam int ACK_TIMEOUT = 150;    // Covers the whole clearing phase
    localparam int DRAIN_TIMEOUT = 10;

    typedef struct packed {
        int due;    // Cycle count when the response is expected
        MemReadSerial serial;
        MemDataPath data;
    } ReadExpect;

    typedef struct packed {
        int due;
        MemWriteSerial serial;
    } WriteExpect;

    logic clk = 1'b0;
    logic negResetIn;
    WbReq wbReq;
    WbResp wbResp;
    MemAccessReq coreReq;
    logic coreRst, memBusy;
    MemReadSerial nextReadSerial;
    MemWriteSerial nextWriteSerial;
    MemReadResp readResp;
    MemWriteResp writeResp;

    logic [31:0] lfsrState = LFSR_SEED;
    MemDataPath model [MEM_WORDS];
    ReadExpect readQ [$];
    WriteExpect writeQ [$];
    MemReadSerial expReadSerial = '0;
    MemWriteSerial expWriteSerial = '0;
    int cycleCount = 0;
    bit armed = 1'b0;       // Checks start once reset is in place
    bit memReady = 1'b0;
    bit coreLocked = 1'b0;
    bit trackCore = 1'b0;   // Scoreboard active, no loader traffic

    MemorySubsystem dut_i (.*);

    always #4 clk = ~clk;

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] expected);
        reportFailure($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected));
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] nextRandom(input int bits);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < bits; i++) begin
            if (lfsrState[0]) lfsrState = (lfsrState >> 1) ^ LFSR_TAPS;
            else lfsrState = lfsrState >> 1;
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    assert property (@(posedge clk) disable iff (!armed) memReady |-> !memBusy)
        else reportFailure("memBusy rose again after clearing ended");
    assert property (@(posedge clk) disable iff (!armed) coreLocked |-> coreRst)
        else reportFailure("coreRst fell before loading ended");
    assert property (@(posedge clk) disable iff (!armed) $past(wbResp.ack) |-> !wbResp.ack)
        else reportFailure("Loader ack lasted more than one cycle");

    // One clock, then compare core responses with the scoreboard
    task automatic advanceCycle();
        ReadExpect rdExp;
        WriteExpect wrExp;
        @(negedge clk);
        cycleCount++;
        if (trackCore) begin
            if (readQ.size() > 0 && readQ[0].due == cycleCount) begin
                rdExp = readQ.pop_front();
                assert (readResp.valid) else reportFailure("Read response missing on its cycle");
                assert (readResp.serial == rdExp.serial)
                    else reportMismatch("readResp.serial", 32'(readResp.serial), 32'(rdExp.serial));
                assert (readResp.data == rdExp.data)
                    else reportMismatch("readResp.data", readResp.data, rdExp.data);
            end else begin
                assert (!readResp.valid) else reportFailure("Read response with no read pending");
            end
            if (writeQ.size() > 0 && writeQ[0].due == cycleCount) begin
                wrExp = writeQ.pop_front();
                assert (writeResp.valid) else reportFailure("Write response missing on its cycle");
                assert (writeResp.serial == wrExp.serial)
                    else reportMismatch("writeResp.serial", 32'(writeResp.serial),
                                        32'(wrExp.serial));
            end else begin
                assert (!writeResp.valid) else reportFailure("Write response with no write pending");
            end
        end
    endtask

    // Wishbone classic cycle, held until ack
    task automatic busCycle(input logic write, input logic [31:0] adr, input logic [31:0] dat,
                            input bit quickAck, output logic [31:0] rdata);
        int waited;
        waited = 0;
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: write, adr: adr, dat: dat};
        do begin
            advanceCycle();
            waited++;
        end while (!wbResp.ack && waited < ACK_TIMEOUT);
        if (!wbResp.ack) reportFailure("Loader gave no ack within the timeout");
        assert (!quickAck || waited == 1) else reportFailure("Loader ack was not one cycle after stb");
        rdata = wbResp.dat;
        wbReq = '0;
        advanceCycle();
        assert (!wbResp.ack) else reportFailure("Loader acked twice for one cycle");
    endtask

    task automatic issueRead(input MemAddrPath addr);
        assert (nextReadSerial == expReadSerial)
            else reportMismatch("nextReadSerial", 32'(nextReadSerial), 32'(expReadSerial));
        coreReq = '{addr: addr, writeData: '0, re: 1'b1, we: 1'b0};
        readQ.push_back(ReadExpect'{due: cycleCount + 3, serial: expReadSerial, data: model[addr]});
        expReadSerial++;
        advanceCycle();
    endtask

    task automatic issueWrite(input MemAddrPath addr, input MemDataPath data);
        assert (nextWriteSerial == expWriteSerial)
            else reportMismatch("nextWriteSerial", 32'(nextWriteSerial), 32'(expWriteSerial));
        coreReq = '{addr: addr, writeData: data, re: 1'b0, we: 1'b1};
        writeQ.push_back(WriteExpect'{due: cycleCount + 3, serial: expWriteSerial});
        model[addr] = data; // Visible to any later read
        expWriteSerial++;
        advanceCycle();
    endtask

    task automatic drainResponses();
        coreReq = '0;
        for (int t = 0; t < DRAIN_TIMEOUT && (readQ.size() > 0 || writeQ.size() > 0); t++) begin
            advanceCycle();
        end
        if (readQ.size() > 0 || writeQ.size() > 0) reportFailure("Core responses never arrived");
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] adr;
        logic doWrite;
        model = '{default: '0};
        negResetIn = 1'b0;
        wbReq = '0;
        coreReq = '0;
        repeat (2) @(negedge clk);
        negResetIn = 1'b1;
        // Synchronizer plus hold time, from the reset timing
        repeat (RESET_HOLD_CYCLES + 4) advanceCycle();

        assert (coreRst && memBusy) else reportFailure("coreRst or memBusy low after reset");
        assert (!wbResp.ack && !readResp.valid && !writeResp.valid)
            else reportFailure("Response or ack active after reset");
        armed = 1'b1;
        coreLocked = 1'b1;

        busCycle(1'b0, LOADER_DONE_ADDR, '0, 1'b1, rdata);
        assert (rdata == 32'd0) else reportMismatch("wbResp.dat", rdata, 32'd0);

        // First load while the memory still clears
        assert (memBusy) else reportFailure("Memory clearing ended before the first load");
        for (int i = 0; i < 16; i++) begin
            adr = nextRandom(MEM_ADDR_WIDTH);
            model[MemAddrPath'(adr)] = nextRandom(32);
            busCycle(1'b1, adr, model[MemAddrPath'(adr)], 1'b0, rdata);
            expWriteSerial++; // Loader writes take write serials too
            assert (!memBusy) else reportFailure("Load acked while memory was busy");
            memReady = 1'b1;
        end
        busCycle(1'b1, 32'h80, nextRandom(32), 1'b1, rdata); // Outside the map

        // Core traffic before loading must be ignored, memory idle now
        trackCore = 1'b1;
        for (int i = 0; i < 8; i++) begin
            doWrite = 1'(nextRandom(1));
            coreReq = '{addr: MemAddrPath'(nextRandom(MEM_ADDR_WIDTH)), writeData: nextRandom(32),
                        re: ~doWrite, we: doWrite};
            advanceCycle();
        end
        coreReq = '0;
        repeat (3) advanceCycle();
        trackCore = 1'b0;

        coreLocked = 1'b0;
        busCycle(1'b1, LOADER_DONE_ADDR, nextRandom(32), 1'b1, rdata);
        busCycle(1'b0, LOADER_DONE_ADDR, '0, 1'b1, rdata);
        assert (rdata == 32'd1) else reportMismatch("wbResp.dat", rdata, 32'd1);
        assert (!coreRst) else reportFailure("coreRst still high after loading ended");

        trackCore = 1'b1;
        for (int a = 0; a < MEM_WORDS; a++) begin
            issueRead(MemAddrPath'(a));
        end
        drainResponses();

        for (int i = 0; i < 20; i++) begin
            adr = nextRandom(MEM_ADDR_WIDTH);
            issueWrite(MemAddrPath'(adr), nextRandom(32));
            issueRead(MemAddrPath'(adr));
        end
        drainResponses();

        $display("NO ERRORS");
        $finish;
    end

endmodule : MemorySubsystemTb

/* project.f */
hw/MemorySystemTypes.sv
hw/BoardTypes.sv
hw/ResetController.sv
hw/ProgramLoader.sv
hw/MemoryAccessArbiter.sv
hw/PipelinedMemory.sv
hw/MemorySubsystem.sv
verif/MemorySubsystemTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the memory subsystem testbench with Verilator and run it.
# The exit status is the simulator's own status.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module MemorySubsystemTb -f project.f -o simv \
    && ./obj_dir/simv \
    || { echo "Simulation run failed"; exit 1; }
